/* tb.f */
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_array_if.sv
logic/cache_arrays.sv
logic/read_data_select.sv
logic/victim_select.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module dcache_tb -o Vdcache_tb
./obj_dir/Vdcache_tb > sim.log 2>&1
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* testbench/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

    localparam int          KIND_PLAIN  = 0;
    localparam int          KIND_POKE   = 1;               // Extra rd_req while busy
    localparam int          KIND_RESET  = 2;               // Reset before the request
    localparam int          REQ_TIMEOUT = 200;
    localparam logic [31:0] WORD_KEY    = 32'hc3a5_0f96;

    logic        clk;
    logic        rst;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        busy;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [`DCACHE_LINE_BITS-1:0] mem_line;

    string       test_name [$];
    logic [31:0] test_addr [$];
    logic        test_miss [$];
    int          test_kind [$];

    logic [31:0] lfsr_state = 32'h720f_a8a5;
    logic [31:0] poke_addr;
    logic [31:0] last_mem_addr;
    int          mem_req_count  = 0;
    int          rd_valid_count = 0;
    int          error_count    = 0;
    int          timeout_count  = 0;
    logic        stop_run       = 1'b0;

    dcache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_line  (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];  // Taps 32, 22, 2, 1
        return {state[30:0], fb};
    endfunction

    task automatic take_random_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return 32'((tag << (`DCACHE_INDEX_BITS + `DCACHE_OFFSET_BITS))
                   | (set << `DCACHE_OFFSET_BITS) | (word << 2));
    endfunction

    // Memory contents: each word holds its own byte address XOR the key
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ WORD_KEY;
    endfunction

    function automatic logic [`DCACHE_LINE_BITS-1:0] build_line(input logic [31:0] base);
        logic [`DCACHE_LINE_BITS-1:0] line;
        for (int i = 0; i < `DCACHE_LINE_BITS / 32; i++) begin
            line[i*32 +: 32] = expected_word(base + 32'(i * 4));
        end
        return line;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_entry(input string name, input logic [31:0] addr,
                             input logic miss, input int kind);
        test_name.push_back(name);
        test_addr.push_back(addr);
        test_miss.push_back(miss);
        test_kind.push_back(kind);
    endtask

    // ----------------------------------------------------------
    // Memory model
    // ----------------------------------------------------------
    initial begin
        int delay_bits;
        mem_valid = 1'b0;
        mem_line  = '0;
        forever begin
            @(posedge clk);
            if (mem_req === 1'b1) begin
                mem_req_count++;
                last_mem_addr = mem_addr;
                take_random_bits(3, delay_bits);           // 1 to 8 cycles
                repeat (delay_bits) @(posedge clk);
                mem_valid <= 1'b1;
                mem_line  <= build_line(last_mem_addr);
                @(posedge clk);
                mem_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rd_valid === 1'b1) begin
            rd_valid_count++;
        end
    end

    task automatic apply_reset(input string name, input logic [31:0] addr);
        rd_req  <= 1'b1;                                   // Lookup in flight when reset hits
        rd_addr <= addr;
        @(posedge clk);
        rd_req <= 1'b0;
        rst    <= 1'b1;
        repeat (2) @(posedge clk);
        check_value(name, "busy after reset", 32'd0, 32'(busy));
        check_value(name, "rd_valid after reset", 32'd0, 32'(rd_valid));
        check_value(name, "mem_req after reset", 32'd0, 32'(mem_req));
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_request(input int idx);
        int          cyc;
        int          req_before;
        int          valid_before;
        logic [31:0] addr;
        addr         = test_addr[idx];
        req_before   = mem_req_count;
        valid_before = rd_valid_count;
        rd_req  <= 1'b1;                                   // Cycle 0
        rd_addr <= addr;
        @(posedge clk);
        rd_req <= 1'b0;
        @(posedge clk);
        check_value(test_name[idx], "busy in cycle 1", 32'd1, 32'(busy));
        if (test_kind[idx] == KIND_POKE) begin
            rd_req  <= 1'b1;
            rd_addr <= poke_addr;
        end
        cyc = 1;
        do begin
            @(posedge clk);
            rd_req <= 1'b0;
            cyc++;
        end while (rd_valid !== 1'b1 && cyc < REQ_TIMEOUT);
        if (rd_valid !== 1'b1) begin
            $display("Timeout: %s got no rd_valid within %0d cycles", test_name[idx], cyc);
            timeout_count++;
            stop_run = 1'b1;
            return;
        end
        check_value(test_name[idx], "rd_data", expected_word(addr), rd_data);
        if (!test_miss[idx]) begin
            check_value(test_name[idx], "hit latency", 32'd2, 32'(cyc));
        end
        repeat (test_kind[idx] == KIND_POKE ? 12 : 3) @(posedge clk);
        check_value(test_name[idx], "mem_req count", test_miss[idx] ? 32'd1 : 32'd0,
                    32'(mem_req_count - req_before));
        check_value(test_name[idx], "rd_valid count", 32'd1,
                    32'(rd_valid_count - valid_before));
        if (test_miss[idx]) begin
            check_value(test_name[idx], "mem_addr", addr & 32'hffff_ffc0, last_mem_addr);
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus table and main loop
    // ----------------------------------------------------------
    initial begin
        rst       = 1'b1;
        rd_req    = 1'b0;
        rd_addr   = '0;
        poke_addr = make_addr(8, 3, 5);
        add_entry("cold_miss_w0",      make_addr(1, 0, 0),  1'b1, KIND_PLAIN);
        add_entry("same_line_w7",      make_addr(1, 0, 7),  1'b0, KIND_PLAIN);
        add_entry("same_line_w15",     make_addr(1, 0, 15), 1'b0, KIND_PLAIN);
        add_entry("other_set_miss",    make_addr(1, 1, 3),  1'b1, KIND_PLAIN);
        add_entry("set0_still_hits",   make_addr(1, 0, 2),  1'b0, KIND_PLAIN);
        add_entry("set1_hits",         make_addr(1, 1, 9),  1'b0, KIND_PLAIN);
        add_entry("fill_way0",         make_addr(2, 5, 1),  1'b1, KIND_PLAIN);
        add_entry("fill_way1",         make_addr(3, 5, 4),  1'b1, KIND_PLAIN);
        add_entry("fill_way2",         make_addr(4, 5, 6),  1'b1, KIND_PLAIN);
        add_entry("fill_way3",         make_addr(5, 5, 8),  1'b1, KIND_PLAIN);
        add_entry("evict_way0",        make_addr(6, 5, 10), 1'b1, KIND_PLAIN);
        add_entry("second_tag_hits",   make_addr(3, 5, 12), 1'b0, KIND_PLAIN);
        add_entry("first_tag_misses",  make_addr(2, 5, 13), 1'b1, KIND_PLAIN);
        add_entry("req_while_busy",    make_addr(7, 2, 1),  1'b1, KIND_POKE);
        add_entry("ignored_req_cold",  poke_addr,           1'b1, KIND_PLAIN);
        add_entry("hit_before_reset",  make_addr(1, 0, 4),  1'b0, KIND_PLAIN);
        add_entry("miss_after_reset",  make_addr(1, 0, 4),  1'b1, KIND_RESET);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < test_name.size() && !stop_run; i++) begin
            if (test_kind[i] == KIND_RESET) begin
                apply_reset(test_name[i], test_addr[i]);
            end
            run_request(i);
        end

        $display("Done: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/dcache_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_properties (
    input logic                clk,
    input logic                rst,
    input logic                rd_req,
    input logic                busy,
    input logic                rd_valid,
    input logic                mem_req,
    input dcache_pkg::way_oh_t hit_way
);

    // ----------------------------------------------------------
    // Port protocol
    // ----------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst) !(rd_valid && mem_req))
        else $error("rd_valid and mem_req high in the same cycle");

    assert property (@(posedge clk) disable iff (rst) mem_req |-> busy)
        else $error("mem_req while not busy");

    // A request accepted while busy would keep busy high past rd_valid
    assert property (@(posedge clk) disable iff (rst) rd_valid |=> !busy)
        else $error("busy still high after rd_valid");

    assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(rd_req))
        else $error("busy rose without a request");

    assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
        else $error("hit_way has more than one bit set");

endmodule

bind dcache_top dcache_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .rd_req   (rd_req),
    .busy     (busy),
    .rd_valid (rd_valid),
    .mem_req  (mem_req),
    .hit_way  (arr_if.hit_way)
);

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    // CPU port
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    output logic              busy,
    output logic              rd_valid,
    output dcache_pkg::word_t rd_data,
    // Memory port
    output logic              mem_req,
    output dcache_pkg::addr_t mem_addr,
    input  logic              mem_valid,
    input  dcache_pkg::line_t mem_line
);

    dcache_array_if arr_if ();

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    cache_arrays arrays_i (
        .clk (clk),
        .rst (rst),
        .arr (arr_if.array)
    );

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    dcache_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_line  (mem_line),
        .arr       (arr_if.ctrl)
    );

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_req,
    input  dcache_pkg::addr_t   rd_addr,
    output logic                busy,
    output logic                rd_valid,
    output dcache_pkg::word_t   rd_data,
    output logic                mem_req,
    output dcache_pkg::addr_t   mem_addr,
    input  logic                mem_valid,
    input  dcache_pkg::line_t   mem_line,
    dcache_array_if.ctrl        arr
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::addr_t       req_addr;
    dcache_pkg::index_t      req_index;
    dcache_pkg::tag_t        req_tag;
    dcache_pkg::way_oh_t     victim_way;
    dcache_pkg::word_t       sel_word;
    logic                    accept;
    logic                    hit;
    logic                    refill_done;
    logic                    load_data;

    assign accept      = rd_req && (state == dcache_pkg::IDLE);
    assign hit         = |arr.hit_way;             // The single hit/miss decision
    assign refill_done = (state == dcache_pkg::REFILL_WAIT) && mem_valid;
    assign load_data   = ((state == dcache_pkg::LOOKUP) && hit) || refill_done;

    assign req_index = req_addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign req_tag   = req_addr[`DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS +: `DCACHE_TAG_BITS];

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= rd_addr;
        end
    end

    // ----------------------------------------------------------
    // Request FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (accept) begin
                        state <= dcache_pkg::LOOKUP;
                    end
                end
                dcache_pkg::LOOKUP: begin
                    state <= hit ? dcache_pkg::RESPOND : dcache_pkg::REFILL_REQ;
                end
                dcache_pkg::REFILL_REQ: state <= dcache_pkg::REFILL_WAIT;
                dcache_pkg::REFILL_WAIT: begin
                    if (mem_valid) begin
                        state <= dcache_pkg::RESPOND;
                    end
                end
                default: state <= dcache_pkg::IDLE;   // RESPOND ends the request
            endcase
        end
    end

    assign busy     = (state != dcache_pkg::IDLE);
    assign mem_req  = (state == dcache_pkg::REFILL_REQ);
    assign mem_addr = {req_addr[$bits(dcache_pkg::addr_t)-1:`DCACHE_OFFSET_BITS],
                       {`DCACHE_OFFSET_BITS{1'b0}}};

    // ----------------------------------------------------------
    // Array access
    // ----------------------------------------------------------
    assign arr.index = (state == dcache_pkg::IDLE)
                       ? rd_addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS] : req_index;
    assign arr.rd_en      = accept;                // Lookup starts in the request cycle
    assign arr.lookup_tag = req_tag;
    assign arr.wr_en      = refill_done;
    assign arr.wr_way     = victim_way;
    assign arr.wr_tag     = req_tag;
    assign arr.wr_line    = mem_line;

    victim_select victim_i (
        .clk        (clk),
        .rst        (rst),
        .index      (req_index),
        .advance    (refill_done),
        .victim_way (victim_way)
    );

    read_data_select rdsel_i (
        .way_lines   (arr.way_lines),
        .hit_way     (arr.hit_way),
        .refill_line (mem_line),
        .word_sel    (req_addr[`DCACHE_OFFSET_BITS-1:2]),
        .from_array  (state == dcache_pkg::LOOKUP),
        .rd_word     (sel_word)
    );

    // Response
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (load_data) begin
            rd_data <= sel_word;
        end
    end

endmodule

`default_nettype wire

/* logic/victim_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module victim_select (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index,
    input  logic                advance,
    output dcache_pkg::way_oh_t victim_way
);

    logic [1:0] rr_ptr [`DCACHE_SETS];             // Next way to fill, per set

    // ----------------------------------------------------------
    // Round-robin pointers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                rr_ptr[s] <= 2'd0;
            end
        end else if (advance) begin
            rr_ptr[index] <= rr_ptr[index] + 2'd1;  // Wraps 3 -> 0
        end
    end

    always_comb begin
        case (rr_ptr[index])
            2'd0:    victim_way = 4'b0001;
            2'd1:    victim_way = 4'b0010;
            2'd2:    victim_way = 4'b0100;
            default: victim_way = 4'b1000;
        endcase
    end

endmodule

`default_nettype wire

/* logic/read_data_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module read_data_select (
    input  dcache_pkg::ways_line_t way_lines,
    input  dcache_pkg::way_oh_t    hit_way,
    input  dcache_pkg::line_t      refill_line,
    input  logic [3:0]             word_sel,
    input  logic                   from_array,
    output dcache_pkg::word_t      rd_word
);

    dcache_pkg::line_t hit_line;
    dcache_pkg::word_t array_word;
    dcache_pkg::word_t refill_word;

    // Word number sel out of a full line
    function automatic dcache_pkg::word_t pick_word(
        input dcache_pkg::line_t line,
        input logic [3:0]        sel
    );
        return line[sel*$bits(dcache_pkg::word_t) +: $bits(dcache_pkg::word_t)];
    endfunction

    // ----------------------------------------------------------
    // Hitting way
    // ----------------------------------------------------------
    always_comb begin
        case (hit_way)
            4'b0001: hit_line = way_lines[0*`DCACHE_LINE_BITS +: `DCACHE_LINE_BITS];
            4'b0010: hit_line = way_lines[1*`DCACHE_LINE_BITS +: `DCACHE_LINE_BITS];
            4'b0100: hit_line = way_lines[2*`DCACHE_LINE_BITS +: `DCACHE_LINE_BITS];
            4'b1000: hit_line = way_lines[3*`DCACHE_LINE_BITS +: `DCACHE_LINE_BITS];
            default: hit_line = '0;                // No hit
        endcase
    end

    // ----------------------------------------------------------
    // Word select
    // ----------------------------------------------------------
    assign array_word  = pick_word(hit_line, word_sel);
    assign refill_word = pick_word(refill_line, word_sel);

    always_comb begin
        if (from_array) begin
            rd_word = array_word;
        end else begin
            rd_word = refill_word;                 // Miss is served from the refill
        end
    end

endmodule

`default_nettype wire

/* logic/cache_arrays.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module cache_arrays (
    input logic           clk,
    input logic           rst,
    dcache_array_if.array arr
);

    dcache_pkg::tag_t    tag_mem  [4][`DCACHE_SETS];
    dcache_pkg::line_t   data_mem [4][`DCACHE_SETS];
    dcache_pkg::way_oh_t valid_bits [`DCACHE_SETS];

    dcache_pkg::tag_t       rd_tags [4];           // Registered tags of the read set
    dcache_pkg::way_oh_t    read_valid;
    dcache_pkg::ways_line_t rd_lines;
    dcache_pkg::way_oh_t    hit_vec;

    // ----------------------------------------------------------
    // Tag and data storage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int w = 0; w < 4; w++) begin
            if (arr.wr_en && arr.wr_way[w]) begin
                tag_mem[w][arr.index]  <= arr.wr_tag;
                data_mem[w][arr.index] <= arr.wr_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < 4; w++) begin
                rd_tags[w] <= tag_mem[w][arr.index];
                rd_lines[w*`DCACHE_LINE_BITS +: `DCACHE_LINE_BITS] <= data_mem[w][arr.index];
            end
        end
    end

    // ----------------------------------------------------------
    // Valid flags
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_bits[s] <= '0;
            end
            read_valid <= '0;
        end else begin
            if (arr.wr_en) begin
                valid_bits[arr.index] <= valid_bits[arr.index] | arr.wr_way;
            end
            if (arr.rd_en) begin
                read_valid <= valid_bits[arr.index];
            end
        end
    end

    // Tag compare on the registered set
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            hit_vec[w] = read_valid[w] && (rd_tags[w] == arr.lookup_tag);
        end
    end

    assign arr.hit_way   = hit_vec;
    assign arr.way_lines = rd_lines;

endmodule

`default_nettype wire

/* logic/dcache_array_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface dcache_array_if;

    dcache_pkg::index_t     index;       // Set for read or write
    logic                   rd_en;       // One-cycle read strobe
    logic                   wr_en;
    dcache_pkg::way_oh_t    wr_way;
    dcache_pkg::tag_t       wr_tag;
    dcache_pkg::line_t      wr_line;
    dcache_pkg::tag_t       lookup_tag;  // Compared against the read tags
    dcache_pkg::way_oh_t    hit_way;
    dcache_pkg::ways_line_t way_lines;   // All four lines of the read set

    modport ctrl (
        output index,
        output rd_en,
        output wr_en,
        output wr_way,
        output wr_tag,
        output wr_line,
        output lookup_tag,
        input  hit_way,
        input  way_lines
    );

    modport array (
        input  index,
        input  rd_en,
        input  wr_en,
        input  wr_way,
        input  wr_tag,
        input  wr_line,
        input  lookup_tag,
        output hit_way,
        output way_lines
    );

endinterface

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;                           // Byte address
    typedef logic [31:0] word_t;                           // CPU data word
    typedef logic [`DCACHE_LINE_BITS-1:0] line_t;          // One cache line
    typedef logic [4*`DCACHE_LINE_BITS-1:0] ways_line_t;   // Way 0 in the low bits
    typedef logic [3:0] way_oh_t;                          // One-hot way
    typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

    // ----------------------------------------------------------
    // Controller FSM
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,                                            // Array outputs valid
        REFILL_REQ,                                        // mem_req cycle
        REFILL_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ----------------------------------------------------------
// Cache geometry
// ----------------------------------------------------------

`define DCACHE_SETS 16                // Sets per way
`define DCACHE_INDEX_BITS 4           // log2 of the set count
`define DCACHE_LINE_BITS 512          // 64-byte line
`define DCACHE_OFFSET_BITS 6          // Byte offset inside a line

// Address bits left over for the tag
`define DCACHE_TAG_BITS (32 - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

`endif
